//--- Makefile
TOP = tb_rv_core

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f $(wildcard source/*.sv source/*.svh testbench/*.sv)
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- source/rv_alu.sv
`include "rv_consts.svh"

module rv_alu (
    input  rv_pkg::alu_op_e     op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] y
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];                 // Only low five bits shift

    always_comb begin
        case (op)
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_SLL:    y = a << shamt;
            ALU_SLT:    y = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:   y = {31'd0, a < b};
            ALU_XOR:    y = a ^ b;
            ALU_SRL:    y = a >> shamt;
            ALU_SRA:    y = $unsigned($signed(a) >>> shamt);
            ALU_OR:     y = a | b;
            ALU_AND:    y = a & b;
            ALU_PASS_B: y = b;
            default:    y = '0;
        endcase
    end

endmodule

//--- source/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath width
`define RV_XLEN 32

// Memory depths in words, and their word address widths
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256
`define RV_IMEM_AW 8
`define RV_DMEM_AW 8

// First fetch address after reset or while idle
`define RV_RESET_PC 32'h0000_0000

`endif

//--- source/rv_core.sv
`include "rv_consts.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   run,
    input  logic                   prog_we,
    input  logic [`RV_IMEM_AW-1:0] prog_addr,
    input  logic [`RV_XLEN-1:0]    prog_data,
    output logic                   st_valid,
    output logic [`RV_XLEN-1:0]    st_addr,
    output logic [`RV_XLEN-1:0]    st_data
);
    fetch_exec_if fe_if ();
    exec_wb_if    ew_if ();

    // Register file ports
    logic [4:0]          rf_raddr1, rf_raddr2;
    logic [`RV_XLEN-1:0] rf_rdata1, rf_rdata2;
    logic                rf_we;
    logic [4:0]          rf_waddr;
    logic [`RV_XLEN-1:0] rf_wdata;

    rv_fetch fetch_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .fe        (fe_if.fetch)
    );

    rv_execute execute_i (
        .clk    (clk),
        .arst_n (arst_n),
        .fe     (fe_if.exec),
        .ew     (ew_if.exec),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    rv_regfile regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    rv_writeback writeback_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .ew       (ew_if.wb),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .st_valid (st_valid),
        .st_addr  (st_addr),
        .st_data  (st_data)
    );

endmodule

//--- source/rv_execute.sv
`include "rv_consts.svh"

module rv_execute (
    input  logic                clk,
    input  logic                arst_n,
    fetch_exec_if.exec          fe,
    exec_wb_if.exec             ew,
    output logic [4:0]          raddr1,
    output logic [4:0]          raddr2,
    input  logic [`RV_XLEN-1:0] rdata1,
    input  logic [`RV_XLEN-1:0] rdata2
);
    import rv_pkg::*;

    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] op_a, op_b, alu_b, alu_y;
    alu_op_e             alu_op;
    wb_src_e             dec_wb_src;
    logic                known, use_imm, dec_reg_we, dec_mem_we;
    logic                is_branch, is_jal, taken;

    // funct3 to ALU operation, shared by OP and OP-IMM
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt,
                                          input logic sub_ok);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(fe.inst[6:0]);
    assign funct3 = fe.inst[14:12];
    assign raddr1 = fe.inst[19:15];
    assign raddr2 = fe.inst[24:20];

    assign imm_i = {{20{fe.inst[31]}}, fe.inst[31:20]};
    assign imm_s = {{20{fe.inst[31]}}, fe.inst[31:25], fe.inst[11:7]};
    assign imm_b = {{19{fe.inst[31]}}, fe.inst[31], fe.inst[7], fe.inst[30:25],
                    fe.inst[11:8], 1'b0};
    assign imm_u = {fe.inst[31:12], 12'd0};
    assign imm_j = {{11{fe.inst[31]}}, fe.inst[31], fe.inst[19:12], fe.inst[20],
                    fe.inst[30:21], 1'b0};

    always_comb begin
        known      = 1'b1;
        use_imm    = 1'b0;
        imm        = imm_i;
        alu_op     = ALU_ADD;
        dec_wb_src = WB_ALU;
        dec_reg_we = 1'b0;
        dec_mem_we = 1'b0;
        is_branch  = 1'b0;
        is_jal     = 1'b0;
        case (opcode)
            OP_LUI: begin
                imm        = imm_u;
                use_imm    = 1'b1;
                alu_op     = ALU_PASS_B;
                dec_reg_we = 1'b1;
            end
            OP_JAL: begin
                imm        = imm_j;
                is_jal     = 1'b1;
                dec_wb_src = WB_PC4;                  // Link register gets pc + 4
                dec_reg_we = 1'b1;
            end
            OP_BRANCH: begin
                imm       = imm_b;
                is_branch = 1'b1;
            end
            OP_LOAD: begin
                use_imm    = 1'b1;
                dec_wb_src = WB_MEM;
                dec_reg_we = 1'b1;
            end
            OP_STORE: begin
                imm        = imm_s;
                use_imm    = 1'b1;
                dec_mem_we = 1'b1;
            end
            OP_IMM: begin
                use_imm    = 1'b1;
                alu_op     = f3_to_alu(funct3, fe.inst[30], 1'b0);
                dec_reg_we = 1'b1;
            end
            OP_REG: begin
                alu_op     = f3_to_alu(funct3, fe.inst[30], 1'b1);
                dec_reg_we = 1'b1;
            end
            default: known = 1'b0;                    // Unknown opcode, bubble
        endcase
    end

    // Writeback to execute forwarding, loads included
    assign op_a = (ew.reg_we && ew.rd != 5'd0 && ew.rd == raddr1) ? ew.wb_data : rdata1;
    assign op_b = (ew.reg_we && ew.rd != 5'd0 && ew.rd == raddr2) ? ew.wb_data : rdata2;
    assign alu_b = use_imm ? imm : op_b;

    always_comb begin
        case (funct3)
            3'b000:  taken = (op_a == op_b);                     // BEQ
            3'b001:  taken = (op_a != op_b);                     // BNE
            3'b100:  taken = ($signed(op_a) < $signed(op_b));    // BLT
            3'b101:  taken = ($signed(op_a) >= $signed(op_b));   // BGE
            default: taken = 1'b0;
        endcase
    end

    assign fe.redirect    = fe.valid && (is_jal || (is_branch && taken));
    assign fe.redirect_pc = fe.pc + imm;

    rv_alu alu_i (
        .op (alu_op),
        .a  (op_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ew.valid  <= 1'b0;
            ew.reg_we <= 1'b0;
            ew.mem_we <= 1'b0;
        end else begin
            ew.valid  <= fe.valid && known;
            ew.reg_we <= fe.valid && known && dec_reg_we;
            ew.mem_we <= fe.valid && known && dec_mem_we;
        end
    end

    always_ff @(posedge clk) begin
        ew.wb_src     <= dec_wb_src;
        ew.rd         <= fe.inst[11:7];
        ew.alu_out    <= alu_y;
        ew.store_data <= op_b;
        ew.pc4        <= fe.pc + 32'd4;
    end

    // Wrong-path fetch is killed after a redirect
    a_redirect_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        fe.redirect |=> !fe.valid)
        else $error("Redirect not followed by a bubble");

endmodule

//--- source/rv_fetch.sv
`include "rv_consts.svh"

module rv_fetch (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   run,
    input  logic                   prog_we,
    input  logic [`RV_IMEM_AW-1:0] prog_addr,
    input  logic [`RV_XLEN-1:0]    prog_data,
    fetch_exec_if.fetch            fe
);
    logic [`RV_XLEN-1:0] imem [`RV_IMEM_WORDS];
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] imem_rdata;

    assign imem_rdata = imem[pc[`RV_IMEM_AW+1:2]];    // Word index of the PC

    // Program load port, used while idle
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= `RV_RESET_PC;
            fe.valid <= 1'b0;
        end else if (!run) begin
            pc       <= `RV_RESET_PC;                 // Parked while idle
            fe.valid <= 1'b0;
        end else if (fe.redirect) begin
            pc       <= fe.redirect_pc;
            fe.valid <= 1'b0;                         // Kill the wrong-path fetch
        end else begin
            pc       <= pc + 32'd4;
            fe.valid <= 1'b1;
        end
    end

    // Fetch register payload
    always_ff @(posedge clk) begin
        if (run && !fe.redirect) begin
            fe.pc   <= pc;
            fe.inst <= imem_rdata;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else $error("PC not word aligned");

    a_no_load_while_run: assert property (@(posedge clk) disable iff (!arst_n)
        !(prog_we && run))
        else $error("Program write while core running");

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B                // LUI immediate straight through
    } alu_op_e;

    // Source of the register writeback value
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4                    // Link value for JAL
    } wb_src_e;

endpackage

//--- source/rv_regfile.sv
`include "rv_consts.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [4:0]          raddr1,
    input  logic [4:0]          raddr2,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2,
    input  logic                we,
    input  logic [4:0]          waddr,
    input  logic [`RV_XLEN-1:0] wdata
);
    logic [`RV_XLEN-1:0] regs [1:31];    // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- source/rv_stage_if.sv
`include "rv_consts.svh"

interface fetch_exec_if;
    logic                valid;           // Fetch register holds a live instruction
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] inst;
    logic                redirect;        // Taken branch or JAL
    logic [`RV_XLEN-1:0] redirect_pc;

    modport fetch (output valid, pc, inst, input redirect, redirect_pc);
    modport exec (input valid, pc, inst, output redirect, redirect_pc);
endinterface

interface exec_wb_if;
    logic                valid;
    rv_pkg::wb_src_e     wb_src;
    logic [4:0]          rd;
    logic                reg_we;
    logic                mem_we;
    logic [`RV_XLEN-1:0] alu_out;         // Result or memory byte address
    logic [`RV_XLEN-1:0] store_data;
    logic [`RV_XLEN-1:0] pc4;
    logic [`RV_XLEN-1:0] wb_data;         // Back to execute for forwarding

    modport exec (
        output valid, wb_src, rd, reg_we, mem_we, alu_out, store_data, pc4,
        input  wb_data
    );
    modport wb (
        input  valid, wb_src, rd, reg_we, mem_we, alu_out, store_data, pc4,
        output wb_data
    );
endinterface

//--- source/rv_writeback.sv
`include "rv_consts.svh"

module rv_writeback (
    input  logic                clk,
    input  logic                arst_n,
    exec_wb_if.wb               ew,
    output logic                rf_we,
    output logic [4:0]          rf_waddr,
    output logic [`RV_XLEN-1:0] rf_wdata,
    output logic                st_valid,
    output logic [`RV_XLEN-1:0] st_addr,
    output logic [`RV_XLEN-1:0] st_data
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0]    dmem [`RV_DMEM_WORDS];
    logic [`RV_DMEM_AW-1:0] dmem_idx;
    logic [`RV_XLEN-1:0]    load_data;
    logic                   store_en;

    assign dmem_idx  = ew.alu_out[`RV_DMEM_AW+1:2];   // Word accesses only
    assign load_data = dmem[dmem_idx];
    assign store_en  = ew.valid && ew.mem_we;

    always_ff @(posedge clk) begin
        if (store_en) begin
            dmem[dmem_idx] <= ew.store_data;
        end
    end

    always_comb begin
        case (ew.wb_src)
            WB_MEM:  ew.wb_data = load_data;
            WB_PC4:  ew.wb_data = ew.pc4;
            default: ew.wb_data = ew.alu_out;
        endcase
    end

    assign rf_we    = ew.valid && ew.reg_we;
    assign rf_waddr = ew.rd;
    assign rf_wdata = ew.wb_data;

    // Store visible at the core boundary
    assign st_valid = store_en;
    assign st_addr  = ew.alu_out;
    assign st_data  = ew.store_data;

    a_store_no_rf_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(st_valid && rf_we))
        else $error("Store and register write in the same cycle");

endmodule

//--- src.f
+incdir+source
source/rv_pkg.sv
source/rv_stage_if.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_fetch.sv
source/rv_execute.sv
source/rv_writeback.sv
source/rv_core.sv
testbench/tb_rv_core.sv

//--- testbench/core_trace.txt
# T name instruction_count(decimal) | P word_addr instruction | E byte_addr data
# P and E fields are hex; E lines are in store order; each program ends in a JAL x0 self loop
T alu_x0 16
P 00 123450b7
P 01 ffb00113
P 02 00300193
P 03 40218233
P 04 00402023
P 05 403152b3
P 06 00502223
P 07 00312333
P 08 003133b3
P 09 00602423
P 0a 00702623
P 0b 0ff0c413
P 0c 00802823
P 0d 00700013
P 0e 00002a23
P 0f 0000006f
E 00 00000008
E 04 ffffffff
E 08 00000001
E 0c 00000000
E 10 123450ff
E 14 00000000
T mem_fwd 7
P 00 12300093
P 01 04102023
P 02 04002103
P 03 002101b3
P 04 04302223
P 05 04202423
P 06 0000006f
E 40 00000123
E 44 00000246
E 48 00000123
T branch 22
P 00 fff00093
P 01 00100113
P 02 00208463
P 03 00202023
P 04 00209463
P 05 00102223
P 06 0020c463
P 07 00102423
P 08 0020d463
P 09 00102623
P 0a 00115463
P 0b 00102823
P 0c 008001ef
P 0d 00102a23
P 0e 00302c23
P 0f 00210463
P 10 00102e23
P 11 00211463
P 12 02202023
P 13 00114463
P 14 02302223
P 15 0000006f
E 00 00000001
E 0c ffffffff
E 18 00000034
E 20 00000001
E 24 00000034

//--- testbench/tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 20;
    localparam int DRAIN_CYCLES = 8;      // Quiet window after the last expected store
    localparam int MAX_TESTS    = 8;
    localparam int MAX_PROG     = 128;
    localparam int MAX_STORES   = 64;

    logic        clk;
    logic        arst_n;
    logic        run;
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [31:0] prog_data;
    logic        st_valid;
    logic [31:0] st_addr;
    logic [31:0] st_data;

    // Trace contents, one slice of the flat arrays per test
    string       t_name  [MAX_TESTS];
    int          t_count [MAX_TESTS];
    int          p_first [MAX_TESTS];
    int          p_num   [MAX_TESTS];
    int          e_first [MAX_TESTS];
    int          e_num   [MAX_TESTS];
    logic [7:0]  p_addr  [MAX_PROG];
    logic [31:0] p_inst  [MAX_PROG];
    logic [31:0] e_addr  [MAX_STORES];
    logic [31:0] e_data  [MAX_STORES];
    int          n_tests;
    int          n_prog;
    int          n_exp;

    int errors;
    int tests_run;
    int tests_failed;
    int cycles      = 0;
    int cycle_limit = 100000;             // Replaced once the trace is known

    rv_core rv_core_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .st_valid  (st_valid),
        .st_addr   (st_addr),
        .st_data   (st_data)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic wait_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_values(input string test, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic reset_core();
        wait_drive_slot();
        arst_n  = 1'b0;
        run     = 1'b0;
        prog_we = 1'b0;
        repeat (RESET_CYCLES) wait_drive_slot();
        arst_n = 1'b1;
    endtask

    // Writes one test's program words through the load port
    task automatic load_program(input int t);
        for (int i = 0; i < p_num[t]; i++) begin
            wait_drive_slot();
            prog_we   = 1'b1;
            prog_addr = p_addr[p_first[t] + i];
            prog_data = p_inst[p_first[t] + i];
        end
        wait_drive_slot();
        prog_we = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic read_trace();
        int          fd;
        int          rc;
        int          k;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        n_tests = 0;
        n_prog  = 0;
        n_exp   = 0;
        fd = $fopen("testbench/core_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/core_trace.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            case (line.getc(0))
                "T": begin
                    k = 2;
                    while (k < line.len() && line.getc(k) != " ") begin
                        k++;
                    end
                    t_name[n_tests]  = line.substr(2, k - 1);
                    rc = $sscanf(line.substr(k, line.len() - 1), "%d", t_count[n_tests]);
                    p_first[n_tests] = n_prog;
                    p_num[n_tests]   = 0;
                    e_first[n_tests] = n_exp;
                    e_num[n_tests]   = 0;
                    n_tests++;
                end
                "P": begin
                    rc = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                    p_addr[n_prog] = a[7:0];
                    p_inst[n_prog] = d;
                    n_prog++;
                    p_num[n_tests - 1]++;
                end
                "E": begin
                    rc = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                    e_addr[n_exp] = a;
                    e_data[n_exp] = d;
                    n_exp++;
                    e_num[n_tests - 1]++;
                end
                default: $display("Trace line not understood: %s", line);
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        int limit;
        int got;
        int waited;
        int errs_before;
        clk          = 1'b0;
        arst_n       = 1'b0;
        run          = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        read_trace();
        cycle_limit = 2 * RESET_CYCLES + IDLE_CYCLES + 6;
        if (n_tests > 0) begin
            cycle_limit += p_num[0];
        end
        for (int t = 0; t < n_tests; t++) begin
            cycle_limit += RESET_CYCLES + p_num[t] + t_count[t] * 8 + 20 + DRAIN_CYCLES + 2;
        end

        // Idle core with a program loaded must not store anything
        reset_core();
        errs_before = errors;
        if (n_tests > 0) begin
            load_program(0);
        end
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            compare_values("idle", "st_valid", 32'd0, {31'd0, st_valid});
        end
        report_test("idle", errs_before);

        for (int t = 0; t < n_tests; t++) begin
            reset_core();
            errs_before = errors;
            load_program(t);
            run = 1'b1;

            limit  = t_count[t] * 8 + 20;
            got    = 0;
            waited = 0;
            while (got < e_num[t] && waited < limit) begin
                @(negedge clk);
                waited++;
                if (st_valid) begin
                    compare_values(t_name[t], "store address", e_addr[e_first[t] + got], st_addr);
                    compare_values(t_name[t], "store data", e_data[e_first[t] + got], st_data);
                    got++;
                end
            end
            if (got < e_num[t]) begin
                $display("%s: only %0d of %0d expected stores appeared", t_name[t], got,
                         e_num[t]);
                errors++;
            end
            repeat (DRAIN_CYCLES) begin
                @(negedge clk);
                if (st_valid) begin
                    $display("%s: unexpected extra store to %h", t_name[t], st_addr);
                    errors++;
                end
            end
            report_test(t_name[t], errs_before);
        end

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0 && n_tests > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
